// File: conv2d_config.svh
`ifndef CONV2D_CONFIG_SVH
`define CONV2D_CONFIG_SVH

`define DMEM_AWIDTH 10   // word address bits of dmem
`define DWIDTH      32   // data word width

`define IO_LATENCY  4    // engine read latency in cycles
`define FIFO_DEPTH  8    // read data buffer, also the credit limit

`define WT_DIM      3    // kernel side
`define FM_DIM_MAX  16   // largest input map side

`define REG_AWIDTH  3    // host register address bits

`endif

// File: mem_pkg.sv
`include "conv2d_config.svh"

package mem_pkg;

    // word address into the data memory
    typedef logic [`DMEM_AWIDTH-1:0] addr_t;

    typedef logic [`DWIDTH-1:0] data_t;    // one memory word

endpackage

// File: conv_pkg.sv
`include "conv2d_config.svh"

package conv_pkg;

    typedef enum logic [`REG_AWIDTH-1:0] {
        REG_CTRL       = 0,    // bit0 starts a run
        REG_STATUS     = 1,    // bit0 idle, bit1 done
        REG_FM_DIM     = 2,
        REG_WT_OFFSET  = 3,
        REG_IFM_OFFSET = 4,
        REG_OFM_OFFSET = 5
    } reg_addr_e;

    typedef enum logic [1:0] {FETCH_IDLE, FETCH_WT, FETCH_WIN} fetch_state_e;

    typedef enum logic [1:0] {MAC_IDLE, MAC_LOAD_WT, MAC_ACCUM, MAC_WRITE} mac_state_e;

endpackage

// File: conv_regs.sv
`include "conv2d_config.svh"

module conv_regs (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               reg_we_i,
    input  conv_pkg::reg_addr_e reg_addr_i,
    input  mem_pkg::data_t     reg_wdata_i,
    output mem_pkg::data_t     reg_rdata_o,
    input  logic               done_i,
    output logic               start_o,
    output logic [4:0]         fm_dim_o,
    output mem_pkg::addr_t     wt_offset_o,
    output mem_pkg::addr_t     ifm_offset_o,
    output mem_pkg::addr_t     ofm_offset_o
);
    import mem_pkg::*;
    import conv_pkg::*;

    logic busy_q;
    logic done_q;
    logic ctrl_go;

    assign ctrl_go = reg_we_i && (reg_addr_i == REG_CTRL) && reg_wdata_i[0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            start_o      <= 1'b0;
            busy_q       <= 1'b0;
            done_q       <= 1'b0;
            fm_dim_o     <= '0;
            wt_offset_o  <= '0;
            ifm_offset_o <= '0;
            ofm_offset_o <= '0;
        end else begin
            start_o <= ctrl_go;    // pulse one cycle after the CTRL write
            if (reg_we_i) begin
                case (reg_addr_i)
                    REG_FM_DIM:     fm_dim_o     <= reg_wdata_i[4:0];
                    REG_WT_OFFSET:  wt_offset_o  <= addr_t'(reg_wdata_i);
                    REG_IFM_OFFSET: ifm_offset_o <= addr_t'(reg_wdata_i);
                    REG_OFM_OFFSET: ofm_offset_o <= addr_t'(reg_wdata_i);
                    default: ;
                endcase
            end
            if (ctrl_go) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;    // sticky done clears on the next start
            end else if (done_i) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_comb begin
        case (reg_addr_i)
            REG_STATUS:     reg_rdata_o = data_t'({done_q, ~busy_q});
            REG_FM_DIM:     reg_rdata_o = data_t'(fm_dim_o);
            REG_WT_OFFSET:  reg_rdata_o = data_t'(wt_offset_o);
            REG_IFM_OFFSET: reg_rdata_o = data_t'(ifm_offset_o);
            REG_OFM_OFFSET: reg_rdata_o = data_t'(ofm_offset_o);
            default:        reg_rdata_o = '0;    // CTRL and unmapped
        endcase
    end

    // host must wait for the previous run to finish
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        start_o |-> !$past(busy_q));

    a_fm_dim_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        start_o |-> (fm_dim_o >= `WT_DIM) && (fm_dim_o <= `FM_DIM_MAX));

endmodule

// File: conv_fetch.sv
`include "conv2d_config.svh"

module conv_fetch (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           start_i,
    input  logic [4:0]     fm_dim_i,
    input  mem_pkg::addr_t wt_offset_i,
    input  mem_pkg::addr_t ifm_offset_i,
    input  logic           credit_i,
    output logic           rd_valid_o,
    output mem_pkg::addr_t rd_addr_o
);
    import mem_pkg::*;
    import conv_pkg::*;

    localparam int CNT_W = $clog2(`FIFO_DEPTH) + 1;

    fetch_state_e     state_q;
    logic [1:0]       ki_q;
    logic [1:0]       kj_q;
    logic [4:0]       row_q;
    logic [4:0]       col_q;
    logic [CNT_W-1:0] outstanding_q;    // requested but not yet popped
    logic [4:0]       last_pos;
    logic             kj_last;
    logic             kern_last;
    addr_t            win_row;

    assign last_pos   = fm_dim_i - 5'(`WT_DIM);
    assign kj_last    = kj_q == 2'(`WT_DIM - 1);
    assign kern_last  = kj_last && (ki_q == 2'(`WT_DIM - 1));
    assign rd_valid_o = (state_q != FETCH_IDLE) && (outstanding_q < CNT_W'(`FIFO_DEPTH));
    assign win_row    = addr_t'(row_q) + addr_t'(ki_q);

    always_comb begin
        if (state_q == FETCH_WT) begin
            rd_addr_o = wt_offset_i + addr_t'(`WT_DIM) * addr_t'(ki_q) + addr_t'(kj_q);
        end else begin
            rd_addr_o = ifm_offset_i + win_row * addr_t'(fm_dim_i) + addr_t'(col_q)
                      + addr_t'(kj_q);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            outstanding_q <= '0;
        end else begin
            outstanding_q <= outstanding_q + CNT_W'(rd_valid_o) - CNT_W'(credit_i);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= FETCH_IDLE;
            ki_q    <= '0;
            kj_q    <= '0;
            row_q   <= '0;
            col_q   <= '0;
        end else if (state_q == FETCH_IDLE) begin
            if (start_i) begin
                state_q <= FETCH_WT;
                ki_q    <= '0;
                kj_q    <= '0;
                row_q   <= '0;
                col_q   <= '0;
            end
        end else if (rd_valid_o) begin
            if (!kern_last) begin
                kj_q <= kj_last ? 2'd0 : kj_q + 2'd1;
                ki_q <= kj_last ? ki_q + 2'd1 : ki_q;
            end else begin
                ki_q <= '0;
                kj_q <= '0;
                if (state_q == FETCH_WT) begin
                    state_q <= FETCH_WIN;    // weights done, first window next
                end else if (col_q != last_pos) begin
                    col_q <= col_q + 5'd1;
                end else begin
                    col_q <= '0;
                    if (row_q != last_pos) begin
                        row_q <= row_q + 5'd1;
                    end else begin
                        state_q <= FETCH_IDLE;
                    end
                end
            end
        end
    end

    a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n_i)
        outstanding_q <= CNT_W'(`FIFO_DEPTH));

endmodule

// File: word_fifo.sv
`include "conv2d_config.svh"

module word_fifo (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           push_i,
    input  mem_pkg::data_t push_data_i,
    output logic           pop_valid_o,
    output mem_pkg::data_t pop_data_o,
    input  logic           pop_ready_i
);
    import mem_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    data_t        mem_q [`FIFO_DEPTH];
    logic [PTR_W:0] wr_ptr_q;    // extra bit tells full from empty
    logic [PTR_W:0] rd_ptr_q;
    logic         full;

    assign full = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W])
               && (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
    assign pop_valid_o = wr_ptr_q != rd_ptr_q;
    assign pop_data_o  = mem_q[rd_ptr_q[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i && !full) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_valid_o && pop_ready_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i && !full) begin
            mem_q[wr_ptr_q[PTR_W-1:0]] <= push_data_i;
        end
    end

    // credits upstream must keep this from ever firing
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        push_i |-> !full);

endmodule

// File: conv_mac.sv
`include "conv2d_config.svh"

module conv_mac (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           start_i,
    input  logic [4:0]     fm_dim_i,
    input  mem_pkg::addr_t ofm_offset_i,
    input  logic           in_valid_i,
    input  mem_pkg::data_t in_data_i,
    output logic           in_ready_o,
    output logic           wr_valid_o,
    output mem_pkg::addr_t wr_addr_o,
    output mem_pkg::data_t wr_data_o,
    output logic           done_o
);
    import mem_pkg::*;
    import conv_pkg::*;

    localparam int KERN_N = `WT_DIM * `WT_DIM;
    localparam int K_W    = $clog2(KERN_N);

    mac_state_e     state_q;
    data_t          wt_q [KERN_N];
    data_t          acc_q;
    logic [K_W-1:0] k_q;          // position inside kernel
    addr_t          out_idx_q;    // row-major output index
    addr_t          out_dim;
    addr_t          out_total;
    logic           fire;
    logic           k_last;
    logic           out_last;

    assign out_dim    = addr_t'(fm_dim_i) - addr_t'(`WT_DIM - 1);
    assign out_total  = out_dim * out_dim;
    assign in_ready_o = (state_q == MAC_LOAD_WT) || (state_q == MAC_ACCUM);
    assign fire       = in_valid_i && in_ready_o;
    assign k_last     = k_q == K_W'(KERN_N - 1);
    assign out_last   = out_idx_q == out_total - addr_t'(1);

    assign wr_valid_o = state_q == MAC_WRITE;
    assign wr_addr_o  = ofm_offset_i + out_idx_q;
    assign wr_data_o  = acc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= MAC_IDLE;
            k_q       <= '0;
            out_idx_q <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                MAC_IDLE: begin
                    if (start_i) begin
                        state_q   <= MAC_LOAD_WT;
                        k_q       <= '0;
                        out_idx_q <= '0;
                    end
                end
                MAC_LOAD_WT, MAC_ACCUM: begin
                    if (fire) begin
                        k_q <= k_last ? '0 : k_q + 1'b1;
                        if (k_last) begin
                            state_q <= (state_q == MAC_LOAD_WT) ? MAC_ACCUM : MAC_WRITE;
                        end
                    end
                end
                MAC_WRITE: begin
                    out_idx_q <= out_idx_q + addr_t'(1);
                    if (out_last) begin
                        state_q <= MAC_IDLE;
                        done_o  <= 1'b1;    // one cycle after the last write
                    end else begin
                        state_q <= MAC_ACCUM;
                    end
                end
                default: state_q <= MAC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == MAC_LOAD_WT) && fire) begin
            wt_q[k_q] <= in_data_i;
        end
        if ((state_q == MAC_LOAD_WT) || (state_q == MAC_WRITE)) begin
            acc_q <= '0;    // fresh sum for the next window
        end else if ((state_q == MAC_ACCUM) && fire) begin
            acc_q <= acc_q + in_data_i * wt_q[k_q];    // wraps at 32 bits
        end
    end

endmodule

// File: dmem_ctrl.sv
`include "conv2d_config.svh"

module dmem_ctrl (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           rd_valid_i,
    input  mem_pkg::addr_t rd_addr_i,
    output logic           resp_valid_o,
    output mem_pkg::data_t resp_data_o,
    input  logic           wr_valid_i,
    input  mem_pkg::addr_t wr_addr_i,
    input  mem_pkg::data_t wr_data_i,
    input  logic           host_we_i,
    input  mem_pkg::addr_t host_addr_i,
    input  mem_pkg::data_t host_wdata_i,
    output mem_pkg::data_t host_rdata_o
);
    import mem_pkg::*;

    localparam int LAT = `IO_LATENCY;

    data_t          mem [2**`DMEM_AWIDTH];
    data_t          dat_sr [LAT];    // stage 0 is the ram output register
    logic [LAT-1:0] vld_sr;
    addr_t          a_addr;
    addr_t          b_addr;
    data_t          b_data;
    logic           b_we;

    // port a reads, port b writes
    assign a_addr = rd_valid_i ? rd_addr_i : host_addr_i;
    assign b_we   = wr_valid_i || host_we_i;
    assign b_addr = wr_valid_i ? wr_addr_i : host_addr_i;
    assign b_data = wr_valid_i ? wr_data_i : host_wdata_i;

    always_ff @(posedge clk) begin
        if (b_we) begin
            mem[b_addr] <= b_data;
        end
    end

    always_ff @(posedge clk) begin
        dat_sr[0] <= mem[a_addr];
        for (int i = 1; i < LAT; i++) begin
            dat_sr[i] <= dat_sr[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[LAT-2:0], rd_valid_i};
        end
    end

    assign resp_valid_o = vld_sr[LAT-1];
    assign resp_data_o  = dat_sr[LAT-1];
    assign host_rdata_o = dat_sr[0];    // host sees data one cycle later

    // host writes only while the engine is quiet, reads in flight included
    a_host_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        host_we_i |-> !(rd_valid_i || wr_valid_i || (|vld_sr)));

endmodule

// File: conv_top.sv
module conv_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                reg_we_i,
    input  conv_pkg::reg_addr_e reg_addr_i,
    input  mem_pkg::data_t      reg_wdata_i,
    output mem_pkg::data_t      reg_rdata_o,
    input  logic                host_we_i,
    input  mem_pkg::addr_t      host_addr_i,
    input  mem_pkg::data_t      host_wdata_i,
    output mem_pkg::data_t      host_rdata_o
);
    import mem_pkg::*;

    logic       start;
    logic       done;
    logic [4:0] fm_dim;
    addr_t      wt_offset;
    addr_t      ifm_offset;
    addr_t      ofm_offset;
    logic       rd_valid;
    addr_t      rd_addr;
    logic       resp_valid;
    data_t      resp_data;
    logic       fifo_valid;
    data_t      fifo_data;
    logic       mac_ready;
    logic       pop_fire;    // credit back to fetch
    logic       wr_valid;
    addr_t      wr_addr;
    data_t      wr_data;

    assign pop_fire = fifo_valid && mac_ready;

    conv_regs u_regs (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .reg_we_i     (reg_we_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .reg_rdata_o  (reg_rdata_o),
        .done_i       (done),
        .start_o      (start),
        .fm_dim_o     (fm_dim),
        .wt_offset_o  (wt_offset),
        .ifm_offset_o (ifm_offset),
        .ofm_offset_o (ofm_offset)
    );

    conv_fetch u_fetch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .start_i      (start),
        .fm_dim_i     (fm_dim),
        .wt_offset_i  (wt_offset),
        .ifm_offset_i (ifm_offset),
        .credit_i     (pop_fire),
        .rd_valid_o   (rd_valid),
        .rd_addr_o    (rd_addr)
    );

    word_fifo u_fifo (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .push_i       (resp_valid),
        .push_data_i  (resp_data),
        .pop_valid_o  (fifo_valid),
        .pop_data_o   (fifo_data),
        .pop_ready_i  (mac_ready)
    );

    conv_mac u_mac (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .start_i      (start),
        .fm_dim_i     (fm_dim),
        .ofm_offset_i (ofm_offset),
        .in_valid_i   (fifo_valid),
        .in_data_i    (fifo_data),
        .in_ready_o   (mac_ready),
        .wr_valid_o   (wr_valid),
        .wr_addr_o    (wr_addr),
        .wr_data_o    (wr_data),
        .done_o       (done)
    );

    dmem_ctrl u_dmem (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .rd_valid_i   (rd_valid),
        .rd_addr_i    (rd_addr),
        .resp_valid_o (resp_valid),
        .resp_data_o  (resp_data),
        .wr_valid_i   (wr_valid),
        .wr_addr_i    (wr_addr),
        .wr_data_i    (wr_data),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_rdata_o (host_rdata_o)
    );

endmodule

// File: tb_clkgen.sv
module tb_clkgen #(
    parameter int PERIOD = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;    // rising edges at 10, 30, 50
        end
    end

endmodule

// File: tb_conv_top.sv
`include "conv2d_config.svh"

module tb_conv_top;
    import mem_pkg::*;
    import conv_pkg::*;

    localparam int MEM_WORDS    = 2 ** `DMEM_AWIDTH;
    localparam int RESET_CYCLES = 8;

    // cycle budget of one run, four times the reads plus read latency
    function automatic int run_budget(input int dim);
        return 4 * (9 + 9 * (dim - 2) * (dim - 2) + `IO_LATENCY);
    endfunction

    localparam int CYCLE_LIMIT = run_budget(3) + run_budget(8) + run_budget(5) + 2000;

    // memory layout of the three runs
    localparam int RUN1_WT  = 16;
    localparam int RUN1_IFM = 32;
    localparam int RUN1_OFM = 64;
    localparam int RUN2_WT  = 100;
    localparam int RUN2_IFM = 128;
    localparam int RUN2_OFM = 256;
    localparam int RUN3_WT  = 400;
    localparam int RUN3_IFM = 416;
    localparam int RUN3_OFM = 512;

    logic      clk;
    logic      rst_n;
    logic      reg_we;
    reg_addr_e reg_addr;
    data_t     reg_wdata;
    data_t     reg_rdata;
    logic      host_we;
    addr_t     host_addr;
    data_t     host_wdata;
    data_t     host_rdata;

    logic      reg_chk;    // stimulus to compare process
    data_t     reg_exp;
    logic      mem_chk;
    data_t     mem_exp;

    data_t     model_mem [MEM_WORDS];    // expected memory contents
    logic [31:0] rng = 32'h2987;
    int        checks = 0;
    int        val_errs = 0;
    int        other_errs = 0;
    int        cycle_cnt = 0;

    tb_clkgen #(.PERIOD(20)) u_clkgen (.clk_o(clk));

    conv_top DUT (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .reg_we_i     (reg_we),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_rdata_o  (reg_rdata),
        .host_we_i    (host_we),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_rdata_o (host_rdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one output word of the valid convolution, from the model memory
    function automatic data_t conv_ref(input int dim, input int wt_off, input int ifm_off,
                                       input int r, input int c);
        data_t acc;
        int    i;
        int    j;
        acc = '0;
        for (i = 0; i < `WT_DIM; i++) begin
            for (j = 0; j < `WT_DIM; j++) begin
                acc = acc + model_mem[addr_t'(wt_off + `WT_DIM * i + j)]
                          * model_mem[addr_t'(ifm_off + (r + i) * dim + c + j)];    // wraps
            end
        end
        return acc;
    endfunction

    task automatic reg_write(input reg_addr_e addr, input data_t data);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_we    = 1'b0;
    endtask

    task automatic reg_expect(input reg_addr_e addr, input data_t exp);
        reg_addr = addr;
        reg_chk  = 1'b1;
        reg_exp  = exp;
        @(negedge clk);
        reg_chk  = 1'b0;
    endtask

    task automatic mem_expect(input addr_t addr, input data_t exp);
        host_addr = addr;
        mem_chk   = 1'b1;
        mem_exp   = exp;
        @(negedge clk);
        mem_chk   = 1'b0;
    endtask

    task automatic load_memory();
        int a;
        for (a = 0; a < MEM_WORDS; a++) begin
            host_we    = 1'b1;
            host_addr  = addr_t'(a);
            host_wdata = model_mem[addr_t'(a)];
            @(negedge clk);
        end
        host_we = 1'b0;
    endtask

    task automatic run_conv(input int dim, input int wt_off, input int ifm_off,
                            input int ofm_off);
        int    od;
        int    r;
        int    c;
        data_t exp;
        od = dim - 2;
        reg_write(REG_FM_DIM, data_t'(dim));
        reg_write(REG_WT_OFFSET, data_t'(wt_off));
        reg_write(REG_IFM_OFFSET, data_t'(ifm_off));
        reg_write(REG_OFM_OFFSET, data_t'(ofm_off));
        reg_write(REG_CTRL, 32'h1);
        reg_expect(REG_STATUS, 32'h0);    // busy, old done cleared
        reg_addr = REG_STATUS;
        do begin
            @(negedge clk);
        end while (!reg_rdata[1]);
        reg_expect(REG_STATUS, 32'h3);    // done and idle again
        for (r = 0; r < od; r++) begin
            for (c = 0; c < od; c++) begin
                exp = conv_ref(dim, wt_off, ifm_off, r, c);
                model_mem[addr_t'(ofm_off + r * od + c)] = exp;
                mem_expect(addr_t'(ofm_off + r * od + c), exp);
            end
        end
    endtask

    task automatic print_summary();
        $display("checks %0d, value errors %0d, other errors %0d", checks, val_errs,
                 other_errs);
    endtask

    // registers sampled at the rising edge, host read data one edge later
    initial begin : compare
        logic  pend;
        data_t exp_q;
        addr_t addr_q;
        pend   = 1'b0;
        exp_q  = '0;
        addr_q = '0;
        forever begin
            @(posedge clk);
            if (reg_chk) begin
                checks++;
                assert (reg_rdata === reg_exp) else begin
                    val_errs++;
                    $display("CHECK FAILED reg_rdata_o addr %h: expected %h, got %h",
                             reg_addr, reg_exp, reg_rdata);
                end
            end
            pend   = mem_chk;
            exp_q  = mem_exp;
            addr_q = host_addr;
            @(negedge clk);
            if (pend) begin
                checks++;
                assert (host_rdata === exp_q) else begin
                    val_errs++;
                    $display("CHECK FAILED host_rdata_o addr %h: expected %h, got %h",
                             addr_q, exp_q, host_rdata);
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        other_errs++;
        $display("timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
        print_summary();
        $display("TB FAILED");
        $finish;
    end

    initial begin : stimulus
        int a;
        int k;
        rst_n      = 1'b0;
        reg_we     = 1'b0;
        reg_addr   = REG_CTRL;
        reg_wdata  = '0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        reg_chk    = 1'b0;
        reg_exp    = '0;
        mem_chk    = 1'b0;
        mem_exp    = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        reg_expect(REG_STATUS, 32'h1);    // idle, nothing done yet
        reg_expect(REG_CTRL, '0);
        reg_expect(REG_FM_DIM, '0);
        reg_expect(REG_WT_OFFSET, '0);
        reg_expect(REG_IFM_OFFSET, '0);
        reg_expect(REG_OFM_OFFSET, '0);

        reg_write(REG_FM_DIM, 32'd11);
        reg_write(REG_WT_OFFSET, 32'h2a5);
        reg_write(REG_IFM_OFFSET, 32'h13c);
        reg_write(REG_OFM_OFFSET, 32'h3ff);
        reg_expect(REG_FM_DIM, 32'd11);
        reg_expect(REG_WT_OFFSET, 32'h2a5);
        reg_expect(REG_IFM_OFFSET, 32'h13c);
        reg_expect(REG_OFM_OFFSET, 32'h3ff);
        reg_expect(reg_addr_e'(3'd6), '0);    // unmapped
        reg_expect(reg_addr_e'(3'd7), '0);

        for (a = 0; a < MEM_WORDS; a++) begin
            rng = xorshift32(rng);
            model_mem[addr_t'(a)] = rng;
        end
        for (k = 0; k < 9; k++) begin
            model_mem[addr_t'(RUN1_WT + k)] = data_t'(k - 4);    // fixed kernel -4..4
        end
        load_memory();

        run_conv(3, RUN1_WT, RUN1_IFM, RUN1_OFM);
        run_conv(8, RUN2_WT, RUN2_IFM, RUN2_OFM);
        run_conv(5, RUN3_WT, RUN3_IFM, RUN3_OFM);

        // whole memory, preloaded words and every output
        for (a = 0; a < MEM_WORDS; a++) begin
            mem_expect(addr_t'(a), model_mem[addr_t'(a)]);
        end
        repeat (2) @(negedge clk);

        print_summary();
        if (val_errs + other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: conv_accel.f
+incdir+.
mem_pkg.sv
conv_pkg.sv
conv_regs.sv
conv_fetch.sv
word_fifo.sv
conv_mac.sv
dmem_ctrl.sv
conv_top.sv
tb_clkgen.sv
tb_conv_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_conv_top
LOG       ?= sim.log
FLIST     ?= conv_accel.f
OBJ_DIR   ?= obj_dir

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
